// ==== Bender.yml ====
package:
  name: exu_stage

sources:
  - hw/rvPkg.sv
  - hw/exuPkg.sv
  - hw/dcacheReqIf.sv
  - hw/alu.sv
  - hw/nextPcGen.sv
  - hw/exu.sv
  - hw/exuTop.sv
  - target: test
    files:
      - test/exuTb.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exuPkg::aluASrcE aluASrc_i,
    input  exuPkg::aluBSrcE aluBSrc_i,
    input  exuPkg::aluOpE   aluOp_i,
    input  logic            isTrunc_i,
    input  logic            isSext_i,
    input  rvPkg::xlenT     pc_i,
    input  rvPkg::xlenT     rs1_i,
    input  rvPkg::xlenT     rs2_i,
    input  rvPkg::xlenT     imm_i,
    output rvPkg::xlenT     aluRes_o,
    output logic            less_o,
    output logic            zero_o
);

    rvPkg::xlenT opA;
    rvPkg::xlenT opB;
    rvPkg::xlenT srlSrc;
    rvPkg::xlenT sraSrc;
    rvPkg::xlenT rawRes;
    logic [5:0]  shamt;
    logic        lessS;
    logic        lessU;

    assign opA = (aluASrc_i == exuPkg::A_SRC_PC) ? pc_i : rs1_i;

    always_comb begin
        case (aluBSrc_i)
            exuPkg::B_SRC_RS2:  opB = rs2_i;
            exuPkg::B_SRC_IMM:  opB = imm_i;
            exuPkg::B_SRC_FOUR: opB = rvPkg::xlenT'(4);
            default:            opB = '0;
        endcase
    end

    // word shifts only look at 5 bits of the amount
    assign shamt = isTrunc_i ? {1'b0, opB[4:0]} : opB[5:0];

    // word right shifts work on the low half, extended as the op needs
    always_comb begin
        if (isTrunc_i) begin
            srlSrc = {{(rvPkg::XLEN-rvPkg::WORD_W){1'b0}}, opA[rvPkg::WORD_W-1:0]};
            sraSrc = {{(rvPkg::XLEN-rvPkg::WORD_W){opA[rvPkg::WORD_W-1]}},
                      opA[rvPkg::WORD_W-1:0]};
        end else begin
            srlSrc = opA;
            sraSrc = opA;
        end
    end

    assign lessS = $signed(opA) < $signed(opB);
    assign lessU = opA < opB;

    always_comb begin
        case (aluOp_i)
            exuPkg::ALU_ADD:   rawRes = opA + opB;
            exuPkg::ALU_SUB:   rawRes = opA - opB;
            exuPkg::ALU_SLL:   rawRes = opA << shamt;
            exuPkg::ALU_SLT:   rawRes = rvPkg::xlenT'(lessS);
            exuPkg::ALU_SLTU:  rawRes = rvPkg::xlenT'(lessU);
            exuPkg::ALU_XOR:   rawRes = opA ^ opB;
            exuPkg::ALU_SRL:   rawRes = srlSrc >> shamt;
            exuPkg::ALU_SRA:   rawRes = rvPkg::xlenT'($signed(sraSrc) >>> shamt);
            exuPkg::ALU_OR:    rawRes = opA | opB;
            exuPkg::ALU_AND:   rawRes = opA & opB;
            exuPkg::ALU_PASSB: rawRes = opB;
            default:           rawRes = '0;
        endcase
    end

    // word ops: cut to 32 bits, then sign or zero extend
    always_comb begin
        if (!isTrunc_i) begin
            aluRes_o = rawRes;
        end else if (isSext_i) begin
            aluRes_o = {{(rvPkg::XLEN-rvPkg::WORD_W){rawRes[rvPkg::WORD_W-1]}},
                        rawRes[rvPkg::WORD_W-1:0]};
        end else begin
            aluRes_o = {{(rvPkg::XLEN-rvPkg::WORD_W){1'b0}}, rawRes[rvPkg::WORD_W-1:0]};
        end
    end

    // flags for the branch unit
    assign less_o = (aluOp_i == exuPkg::ALU_SLTU) ? lessU : lessS;
    assign zero_o = (aluRes_o == '0);

endmodule

`default_nettype wire

// ==== hw/dcacheReqIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dcacheReqIf;

    logic                      req;
    // 1 for a store
    logic                      op;
    logic [1:0]                size;
    rvPkg::xlenT               addr;
    rvPkg::xlenT               wdata;
    logic [rvPkg::STRB_W-1:0]  wstrb;
    logic                      ready;

    // stage side, holds req and fields until ready
    modport requester (
        output req,
        output op,
        output size,
        output addr,
        output wdata,
        output wstrb,
        input  ready
    );

    modport cache (
        input  req,
        input  op,
        input  size,
        input  addr,
        input  wdata,
        input  wstrb,
        output ready
    );

endinterface

`default_nettype wire

// ==== hw/exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  logic               clk_i,
    input  logic               rstN_i,

    input  logic               inValid_i,
    output logic               inAllowin_o,
    input  exuPkg::idToExuT    idToExu_i,

    dcacheReqIf.requester      dcache,

    input  logic               wbAllowin_i,
    output logic               outValid_o,
    output exuPkg::exuToMemT   exuToMem_o,

    output rvPkg::xlenT        nextPc_o,
    output logic               isJump_o
);

    rvPkg::xlenT      aluRes;
    logic             less;
    logic             zero;
    logic             taken;
    logic             readyGo;
    logic             toNextValid;
    logic             pipeWen;
    exuPkg::memCtrlT  memCtrl;
    exuPkg::exuToMemT exuToMemNext;

    assign memCtrl = idToExu_i.memCtrl;

    alu alu0 (
        .aluASrc_i (idToExu_i.aluASrc),
        .aluBSrc_i (idToExu_i.aluBSrc),
        .aluOp_i   (idToExu_i.aluOp),
        .isTrunc_i (idToExu_i.isTrunc),
        .isSext_i  (idToExu_i.isSext),
        .pc_i      (idToExu_i.pc),
        .rs1_i     (idToExu_i.rs1),
        .rs2_i     (idToExu_i.rs2),
        .imm_i     (idToExu_i.imm),
        .aluRes_o  (aluRes),
        .less_o    (less),
        .zero_o    (zero)
    );

    nextPcGen nextPcGen0 (
        .branch_i (idToExu_i.branch),
        .pc_i     (idToExu_i.pc),
        .rs1_i    (idToExu_i.rs1),
        .imm_i    (idToExu_i.imm),
        .less_i   (less),
        .zero_i   (zero),
        .nextPc_o (nextPc_o),
        .taken_o  (taken)
    );

    // cache request, held as long as the input is held
    assign dcache.req   = inValid_i && memCtrl.memEn;
    assign dcache.op    = memCtrl.memWr;
    assign dcache.size  = memCtrl.memSize;
    assign dcache.addr  = aluRes;
    assign dcache.wdata = idToExu_i.rs2;

    // strobes cover the low bytes, no address alignment
    always_comb begin
        case (memCtrl.memSize)
            2'd0:    dcache.wstrb = 8'b0000_0001;
            2'd1:    dcache.wstrb = 8'b0000_0011;
            2'd2:    dcache.wstrb = 8'b0000_1111;
            default: dcache.wstrb = 8'b1111_1111;
        endcase
    end

    // done when no access or the cache takes it now
    assign readyGo     = !dcache.req || dcache.ready;
    assign inAllowin_o = !inValid_i || (readyGo && wbAllowin_i);
    assign toNextValid = inValid_i && readyGo;
    assign pipeWen     = toNextValid && wbAllowin_i;

    assign isJump_o = taken && toNextValid;

    always_comb begin
        exuToMemNext.aluRes  = aluRes;
        exuToMemNext.rs1     = idToExu_i.rs1;
        exuToMemNext.rs2     = idToExu_i.rs2;
        exuToMemNext.memCtrl = memCtrl;
        exuToMemNext.intrEn  = idToExu_i.intrEn;
        exuToMemNext.regWr   = idToExu_i.regWr;
        exuToMemNext.regSrc  = idToExu_i.regSrc;
        exuToMemNext.inst    = idToExu_i.inst;
        exuToMemNext.pc      = idToExu_i.pc;
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            outValid_o <= 1'b0;
        end else if (wbAllowin_i) begin
            outValid_o <= toNextValid;
        end
    end

    // pipeline registers to the memory stage
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            exuToMem_o <= '0;
        end else if (pipeWen) begin
            exuToMem_o <= exuToMemNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/exuPkg.sv ====
`default_nettype none

package exuPkg;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } aluOpE;

    typedef enum logic {
        A_SRC_RS1 = 1'b0,
        A_SRC_PC  = 1'b1
    } aluASrcE;

    typedef enum logic [1:0] {
        B_SRC_RS2  = 2'd0,
        B_SRC_IMM  = 2'd1,
        B_SRC_FOUR = 2'd2
    } aluBSrcE;

    // unsigned compares are blt/bge with ALU_SLTU
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_JAL  = 3'd1,
        BR_JALR = 3'd2,
        BR_BEQ  = 3'd3,
        BR_BNE  = 3'd4,
        BR_BLT  = 3'd5,
        BR_BGE  = 3'd6
    } branchE;

    typedef enum logic [1:0] {
        REG_SRC_ALU = 2'd0,
        REG_SRC_MEM = 2'd1,
        REG_SRC_PC4 = 2'd2
    } regSrcE;

    // memSize is log2 of the access size in bytes
    typedef struct packed {
        logic       memEn;
        logic       memWr;
        logic       memUnsigned;
        logic [1:0] memSize;
    } memCtrlT;

    typedef struct packed {
        rvPkg::instT inst;
        rvPkg::xlenT pc;
        aluASrcE     aluASrc;
        aluBSrcE     aluBSrc;
        aluOpE       aluOp;
        logic        isTrunc;
        logic        isSext;
        branchE      branch;
        logic        regWr;
        regSrcE      regSrc;
        memCtrlT     memCtrl;
        logic        intrEn;
        rvPkg::xlenT rs1;
        rvPkg::xlenT rs2;
        rvPkg::xlenT imm;
    } idToExuT;

    typedef struct packed {
        rvPkg::xlenT aluRes;
        rvPkg::xlenT rs1;
        rvPkg::xlenT rs2;
        memCtrlT     memCtrl;
        logic        intrEn;
        logic        regWr;
        regSrcE      regSrc;
        rvPkg::instT inst;
        rvPkg::xlenT pc;
    } exuToMemT;

endpackage

`default_nettype wire

// ==== hw/exuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module exuTop (
    input  logic                     clk_i,
    input  logic                     rstN_i,

    input  logic                     inValid_i,
    output logic                     inAllowin_o,
    input  exuPkg::idToExuT          idToExu_i,

    output logic                     dcReq_o,
    output logic                     dcOp_o,
    output logic [1:0]               dcSize_o,
    output rvPkg::xlenT              dcAddr_o,
    output rvPkg::xlenT              dcWdata_o,
    output logic [rvPkg::STRB_W-1:0] dcWstrb_o,
    input  logic                     dcReady_i,

    input  logic                     wbAllowin_i,
    output logic                     outValid_o,
    output exuPkg::exuToMemT         exuToMem_o,

    output rvPkg::xlenT              nextPc_o,
    output logic                     isJump_o
);

    dcacheReqIf dcIf ();

    exu exu0 (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .inValid_i   (inValid_i),
        .inAllowin_o (inAllowin_o),
        .idToExu_i   (idToExu_i),
        .dcache      (dcIf.requester),
        .wbAllowin_i (wbAllowin_i),
        .outValid_o  (outValid_o),
        .exuToMem_o  (exuToMem_o),
        .nextPc_o    (nextPc_o),
        .isJump_o    (isJump_o)
    );

    // cache side of the interface out to pins
    assign dcReq_o    = dcIf.req;
    assign dcOp_o     = dcIf.op;
    assign dcSize_o   = dcIf.size;
    assign dcAddr_o   = dcIf.addr;
    assign dcWdata_o  = dcIf.wdata;
    assign dcWstrb_o  = dcIf.wstrb;
    assign dcIf.ready = dcReady_i;

endmodule

`default_nettype wire

// ==== hw/nextPcGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module nextPcGen (
    input  exuPkg::branchE branch_i,
    input  rvPkg::xlenT    pc_i,
    input  rvPkg::xlenT    rs1_i,
    input  rvPkg::xlenT    imm_i,
    input  logic           less_i,
    input  logic           zero_i,
    output rvPkg::xlenT    nextPc_o,
    output logic           taken_o
);

    rvPkg::xlenT pcImm;
    rvPkg::xlenT rs1Imm;
    rvPkg::xlenT seqPc;
    rvPkg::xlenT target;

    assign pcImm  = pc_i + imm_i;
    assign rs1Imm = rs1_i + imm_i;
    assign seqPc  = pc_i + rvPkg::xlenT'(4);

    always_comb begin
        taken_o = 1'b0;
        target  = pcImm;
        case (branch_i)
            exuPkg::BR_JAL: begin
                taken_o = 1'b1;
            end
            exuPkg::BR_JALR: begin
                taken_o = 1'b1;
                // jalr target has bit 0 cleared
                target  = {rs1Imm[rvPkg::XLEN-1:1], 1'b0};
            end
            exuPkg::BR_BEQ: taken_o = zero_i;
            exuPkg::BR_BNE: taken_o = !zero_i;
            exuPkg::BR_BLT: taken_o = less_i;
            exuPkg::BR_BGE: taken_o = !less_i;
            default:        taken_o = 1'b0;
        endcase
    end

    // fall through to pc+4 when not taken
    assign nextPc_o = taken_o ? target : seqPc;

endmodule

`default_nettype wire

// ==== hw/rvPkg.sv ====
`default_nettype none

package rvPkg;

    // register width of the core
    localparam int XLEN = 64;

    // instruction width, no compressed instructions
    localparam int INST_W = 32;

    // width of a word operation (addw, sllw, ...)
    localparam int WORD_W = 32;

    // bytes per register, one strobe bit each
    localparam int STRB_W = XLEN / 8;

    typedef logic [XLEN-1:0] xlenT;

    typedef logic [INST_W-1:0] instT;

endpackage

`default_nettype wire

// ==== list.f ====
hw/rvPkg.sv
hw/exuPkg.sv
hw/dcacheReqIf.sv
hw/alu.sv
hw/nextPcGen.sv
hw/exu.sv
hw/exuTop.sv
test/exuTb.sv

// ==== test/exuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exuTb;

    localparam int NROWS = 18;
    localparam int CLK_NS = 40;
    localparam int WATCHDOG_NS = NROWS * 10 * CLK_NS;
    localparam rvPkg::xlenT PC_BASE = 64'h0000_0000_8000_0000;
    // row 12 of the table is the jal
    localparam int JAL_ROW = 12;

    logic                     clk;
    logic                     rstN;
    logic                     inValid;
    logic                     inAllowin;
    exuPkg::idToExuT          idToExu;
    logic                     dcReq;
    logic                     dcOp;
    logic [1:0]               dcSize;
    rvPkg::xlenT              dcAddr;
    rvPkg::xlenT              dcWdata;
    logic [rvPkg::STRB_W-1:0] dcWstrb;
    logic                     dcReady;
    logic                     wbAllowin;
    logic                     outValid;
    exuPkg::exuToMemT         exuToMem;
    rvPkg::xlenT              nextPc;
    logic                     isJump;

    // vector table with one entry per instruction
    exuPkg::idToExuT          rowIn   [NROWS];
    rvPkg::xlenT              rowAlu  [NROWS];
    rvPkg::xlenT              rowPc   [NROWS];
    logic                     rowJump [NROWS];
    logic                     rowReq  [NROWS];
    logic [1:0]               rowSize [NROWS];
    logic [rvPkg::STRB_W-1:0] rowStrb [NROWS];
    int                       rowCnt;
    int                       outCnt;

    // writeback model state
    logic                     heldLast;
    logic                     prevValid;
    exuPkg::exuToMemT         prevOut;

    exuTop dut0 (
        .clk_i       (clk),
        .rstN_i      (rstN),
        .inValid_i   (inValid),
        .inAllowin_o (inAllowin),
        .idToExu_i   (idToExu),
        .dcReq_o     (dcReq),
        .dcOp_o      (dcOp),
        .dcSize_o    (dcSize),
        .dcAddr_o    (dcAddr),
        .dcWdata_o   (dcWdata),
        .dcWstrb_o   (dcWstrb),
        .dcReady_i   (dcReady),
        .wbAllowin_i (wbAllowin),
        .outValid_o  (outValid),
        .exuToMem_o  (exuToMem),
        .nextPc_o    (nextPc),
        .isJump_o    (isJump)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkWord(input string name, input rvPkg::xlenT got, input rvPkg::xlenT exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkByte(input string name, input logic [rvPkg::STRB_W-1:0] got,
                             input logic [rvPkg::STRB_W-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkOut(input string name, input exuPkg::exuToMemT got,
                            input exuPkg::exuToMemT exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // payload the memory stage should see for row i
    function automatic exuPkg::exuToMemT expectedOut(input int i);
        exuPkg::exuToMemT o;
        o.aluRes  = rowAlu[i];
        o.rs1     = rowIn[i].rs1;
        o.rs2     = rowIn[i].rs2;
        o.memCtrl = rowIn[i].memCtrl;
        o.intrEn  = rowIn[i].intrEn;
        o.regWr   = rowIn[i].regWr;
        o.regSrc  = rowIn[i].regSrc;
        o.inst    = rowIn[i].inst;
        o.pc      = rowIn[i].pc;
        return o;
    endfunction

    // mc is {memEn, memWr, memUnsigned, memSize}
    // expPc only counts for taken rows
    task automatic addRow(
        input exuPkg::aluASrcE aSrc,
        input exuPkg::aluBSrcE bSrc,
        input exuPkg::aluOpE   op,
        input logic [1:0]      truncSext,
        input exuPkg::branchE  br,
        input logic [4:0]      mc,
        input rvPkg::xlenT     r1,
        input rvPkg::xlenT     r2,
        input rvPkg::xlenT     im,
        input rvPkg::xlenT     expAlu,
        input rvPkg::xlenT     expPc,
        input logic            expJump,
        input logic            expReq,
        input logic [1:0]      expSize,
        input logic [7:0]      expStrb
    );
        exuPkg::idToExuT d;
        logic            isLink;
        isLink    = (br == exuPkg::BR_JAL) || (br == exuPkg::BR_JALR);
        d.inst    = 32'h00c0_0013 + rvPkg::instT'(rowCnt);
        d.pc      = PC_BASE + rvPkg::xlenT'(rowCnt) * 16;
        d.aluASrc = aSrc;
        d.aluBSrc = bSrc;
        d.aluOp   = op;
        d.isTrunc = truncSext[1];
        d.isSext  = truncSext[0];
        d.branch  = br;
        d.memCtrl = exuPkg::memCtrlT'(mc);
        d.intrEn  = rowCnt[0];
        d.rs1     = r1;
        d.rs2     = r2;
        d.imm     = im;
        d.regWr   = (br == exuPkg::BR_NONE || isLink) && !d.memCtrl.memWr;
        if (d.memCtrl.memEn && !d.memCtrl.memWr) begin
            d.regSrc = exuPkg::REG_SRC_MEM;
        end else if (isLink) begin
            d.regSrc = exuPkg::REG_SRC_PC4;
        end else begin
            d.regSrc = exuPkg::REG_SRC_ALU;
        end
        rowIn[rowCnt]   = d;
        rowAlu[rowCnt]  = expAlu;
        rowPc[rowCnt]   = expJump ? expPc : d.pc + 64'd4;
        rowJump[rowCnt] = expJump;
        rowReq[rowCnt]  = expReq;
        rowSize[rowCnt] = expSize;
        rowStrb[rowCnt] = expStrb;
        rowCnt++;
    endtask

    // pc of row i is PC_BASE + 16*i
    task automatic buildTable();
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_RS2, exuPkg::ALU_ADD, 2'b00, exuPkg::BR_NONE,
               5'b00000, 64'h1234, 64'h100, 64'h0, 64'h1334, 64'h0, 1'b0, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_IMM, exuPkg::ALU_SUB, 2'b00, exuPkg::BR_NONE,
               5'b00000, 64'h5, 64'h0, 64'h7, 64'hFFFF_FFFF_FFFF_FFFE, 64'h0,
               1'b0, 1'b0, 2'd0, 8'h00);
        // shift amount 0x41 keeps only its low 6 bits
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_RS2, exuPkg::ALU_SLL, 2'b00, exuPkg::BR_NONE,
               5'b00000, 64'h1, 64'h41, 64'h0, 64'h2, 64'h0, 1'b0, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_RS2, exuPkg::ALU_AND, 2'b00, exuPkg::BR_NONE,
               5'b00000, 64'h0000_FFFF_0000_FFFF, 64'h1234_5678_9ABC_DEF0, 64'h0,
               64'h0000_5678_0000_DEF0, 64'h0, 1'b0, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_IMM, exuPkg::ALU_SRA, 2'b00, exuPkg::BR_NONE,
               5'b00000, 64'h8000_0000_0000_0000, 64'h0, 64'h4, 64'hF800_0000_0000_0000,
               64'h0, 1'b0, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_IMM, exuPkg::ALU_PASSB, 2'b00, exuPkg::BR_NONE,
               5'b00000, 64'h0, 64'h0, 64'hFFFF_FFFF_8765_4000, 64'hFFFF_FFFF_8765_4000,
               64'h0, 1'b0, 1'b0, 2'd0, 8'h00);
        // addw overflows into bit 31, then sign extends
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_IMM, exuPkg::ALU_ADD, 2'b11, exuPkg::BR_NONE,
               5'b00000, 64'h7FFF_FFFF, 64'h0, 64'h1, 64'hFFFF_FFFF_8000_0000, 64'h0,
               1'b0, 1'b0, 2'd0, 8'h00);
        // word shift uses 5 bits of 0x24 and zero extends
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_RS2, exuPkg::ALU_SRL, 2'b10, exuPkg::BR_NONE,
               5'b00000, 64'h8000_0000, 64'h24, 64'h0, 64'h0800_0000, 64'h0,
               1'b0, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_RS2, exuPkg::ALU_SUB, 2'b00, exuPkg::BR_BEQ,
               5'b00000, 64'h55, 64'h55, 64'h40, 64'h0, 64'h8000_00C0, 1'b1, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_RS2, exuPkg::ALU_SUB, 2'b00, exuPkg::BR_BNE,
               5'b00000, 64'h7, 64'h7, 64'h40, 64'h0, 64'h0, 1'b0, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_RS2, exuPkg::ALU_SLT, 2'b00, exuPkg::BR_BLT,
               5'b00000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'hFFFF_FFFF_FFFF_FFF0, 64'h1,
               64'h8000_0090, 1'b1, 1'b0, 2'd0, 8'h00);
        // bgeu with all ones not below 1 unsigned
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_RS2, exuPkg::ALU_SLTU, 2'b00, exuPkg::BR_BGE,
               5'b00000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'h20, 64'h0, 64'h8000_00D0,
               1'b1, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_PC, exuPkg::B_SRC_FOUR, exuPkg::ALU_ADD, 2'b00, exuPkg::BR_JAL,
               5'b00000, 64'h0, 64'h0, 64'h800, 64'h8000_00C4, 64'h8000_08C0,
               1'b1, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_PC, exuPkg::B_SRC_FOUR, exuPkg::ALU_ADD, 2'b00, exuPkg::BR_JALR,
               5'b00000, 64'h1001, 64'h0, 64'h10, 64'h8000_00D4, 64'h1010,
               1'b1, 1'b0, 2'd0, 8'h00);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_IMM, exuPkg::ALU_ADD, 2'b00, exuPkg::BR_NONE,
               5'b10000, 64'h1000, 64'h0, 64'h5, 64'h1005, 64'h0, 1'b0, 1'b1, 2'd0, 8'h01);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_IMM, exuPkg::ALU_ADD, 2'b00, exuPkg::BR_NONE,
               5'b10101, 64'h2000, 64'h0, 64'h2, 64'h2002, 64'h0, 1'b0, 1'b1, 2'd1, 8'h03);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_IMM, exuPkg::ALU_ADD, 2'b00, exuPkg::BR_NONE,
               5'b11010, 64'h3000, 64'h1122_3344_5566_7788, 64'h8, 64'h3008, 64'h0,
               1'b0, 1'b1, 2'd2, 8'h0F);
        addRow(exuPkg::A_SRC_RS1, exuPkg::B_SRC_IMM, exuPkg::ALU_ADD, 2'b00, exuPkg::BR_NONE,
               5'b11011, 64'h4000, 64'hDEAD_BEEF_CAFE_F00D, 64'hFFFF_FFFF_FFFF_FFF8,
               64'h3FF8, 64'h0, 1'b0, 1'b1, 2'd3, 8'hFF);
    endtask

    // request, redirect and handshake seen while row i sits at the input
    task automatic checkCombOutputs(input int i);
        logic goExp;
        goExp = !rowReq[i] || dcReady;
        checkBit("dcReq_o", dcReq, rowReq[i]);
        if (rowReq[i]) begin
            checkBit("dcOp_o", dcOp, rowIn[i].memCtrl.memWr);
            checkByte("dcSize_o", {6'b0, dcSize}, {6'b0, rowSize[i]});
            checkWord("dcAddr_o", dcAddr, rowAlu[i]);
            checkWord("dcWdata_o", dcWdata, rowIn[i].rs2);
            checkByte("dcWstrb_o", dcWstrb, rowStrb[i]);
        end
        checkWord("nextPc_o", nextPc, rowPc[i]);
        checkBit("isJump_o", isJump, rowJump[i] && goExp);
        checkBit("inAllowin_o", inAllowin, goExp && wbAllowin);
    endtask

    // present row i, with random cache and writeback stalls, until it is taken
    task automatic runRow(input int i);
        int dcWait;
        int wbWait;
        int waited;
        dcWait    = $urandom % 4;
        wbWait    = $urandom % 4;
        waited    = 0;
        inValid   <= 1'b1;
        idToExu   <= rowIn[i];
        dcReady   <= (dcWait == 0);
        wbAllowin <= (wbWait == 0);
        forever begin
            @(negedge clk);
            // previous row was taken at the last edge
            if (waited == 0 && i > 0) begin
                checkBit("outValid_o", outValid, 1'b1);
            end
            checkCombOutputs(i);
            if (inAllowin) begin
                break;
            end
            @(posedge clk);
            waited++;
            dcReady   <= (waited >= dcWait);
            wbAllowin <= (waited >= wbWait);
        end
        @(posedge clk);
    endtask

    // writeback model takes an output whenever it allows one in
    always @(negedge clk) begin
        if (rstN) begin
            if (heldLast) begin
                checkBit("outValid_o", outValid, prevValid);
                checkOut("exuToMem_o", exuToMem, prevOut);
            end
            if (outValid && wbAllowin) begin
                if (outCnt >= NROWS) begin
                    abortRun("an output appeared after every table row was already seen");
                end else begin
                    checkOut("exuToMem_o", exuToMem, expectedOut(outCnt));
                    outCnt++;
                end
            end
            heldLast  = !wbAllowin;
            prevValid = outValid;
            prevOut   = exuToMem;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abortRun("timeout: the stage did not get through the table in time");
    end

    initial begin
        void'($urandom(32'ha28b));
        clk       = 1'b0;
        rstN      = 1'b0;
        inValid   = 1'b0;
        idToExu   = '0;
        dcReady   = 1'b0;
        wbAllowin = 1'b1;
        rowCnt    = 0;
        outCnt    = 0;
        heldLast  = 1'b0;
        prevValid = 1'b0;
        prevOut   = '0;
        buildTable();
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkBit("outValid_o", outValid, 1'b0);
        checkBit("dcReq_o", dcReq, 1'b0);
        checkBit("isJump_o", isJump, 1'b0);
        checkOut("exuToMem_o", exuToMem, '0);
        @(posedge clk);
        for (int i = 0; i < NROWS; i++) begin
            runRow(i);
        end
        // bubble with a store payload must not request
        inValid   <= 1'b0;
        idToExu   <= rowIn[NROWS-1];
        dcReady   <= 1'b0;
        wbAllowin <= 1'b1;
        @(negedge clk);
        checkBit("outValid_o", outValid, 1'b1);
        checkBit("dcReq_o", dcReq, 1'b0);
        checkBit("inAllowin_o", inAllowin, 1'b1);
        @(posedge clk);
        // bubble with a jal payload must not redirect
        idToExu <= rowIn[JAL_ROW];
        @(negedge clk);
        checkBit("outValid_o", outValid, 1'b0);
        checkBit("isJump_o", isJump, 1'b0);
        checkBit("inAllowin_o", inAllowin, 1'b1);
        @(posedge clk);
        idToExu <= '0;
        wait (outCnt == NROWS);
        // idle a little so a duplicate output would show
        repeat (4) @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
